/* verilog/piano_control_cfg.svh */
`ifndef PIANO_CONTROL_CFG_SVH
`define PIANO_CONTROL_CFG_SVH

// Width of the state code and the debug port
`define STATE_W 5

// Bit 0 selects the game and bit 1 selects free play
`define MODE_SW_W 2

`define TEMPO_W 2

// Bit 2 retries the round, bit 1 the note, bit 0 replays the last note
`define RETRY_SW_W 3

`endif

/* verilog/piano_settings_pkg.sv */
package piano_settings_pkg;

    // Play mode chosen in the first menu step
    typedef enum logic [1:0] {
        MODE_NONE = 2'd0,
        MODE_GAME = 2'd1,
        MODE_FREE = 2'd2
    } play_mode_t;

    // Choice taken from the error menu
    typedef enum logic [1:0] {
        RETRY_NONE  = 2'd0,
        RETRY_ROUND = 2'd1,
        RETRY_NOTE  = 2'd2,
        REPLAY_LAST = 2'd3
    } retry_choice_t;

endpackage

/* verilog/piano_state_pkg.sv */
`include "piano_control_cfg.svh"

package piano_state_pkg;

    // Codes are fixed since they show up on the debug port
    typedef enum logic [`STATE_W-1:0] {
        // --------------------
        // Menu
        ST_IDLE           = 0,
        ST_MENU_START     = 1,
        ST_WAIT_MODE      = 2,
        ST_WAIT_TEMPO     = 3,
        ST_INIT           = 4,

        // --------------------
        // Song shown up to the round
        ST_ROUND_START    = 5,
        ST_SHOW           = 6,
        ST_SHOW_WAIT      = 7,
        ST_SHOW_NEXT      = 8,

        // --------------------
        // Player repeats the song
        ST_NOTE_START     = 9,
        ST_NOTE_WAIT      = 10,
        ST_NOTE_PLAY      = 11,
        ST_COMPARE        = 12,
        ST_NEXT_NOTE      = 13,

        // --------------------
        // Round finished
        ST_ADVANCE        = 14,
        ST_REGISTER       = 15,
        ST_CHECK_END      = 16,
        ST_ROUND_NEXT     = 17,
        ST_WON            = 18,

        // --------------------
        // Errors and free play
        ST_MISS_NOTE      = 19,
        ST_MISS_TIME      = 20,
        ST_ERR_MENU_START = 21,
        ST_ERR_MENU       = 22,
        ST_SHOW_LAST      = 23,
        ST_FREE_WAIT      = 24
    } seq_state_t;

endpackage

/* verilog/settings_registers.sv */
`timescale 1ns/1ns
`include "piano_control_cfg.svh"

module settings_registers
    import piano_settings_pkg::*;
(
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   capture_mode,
    input  logic                   capture_tempo,
    input  logic                   capture_retry,
    input  logic [`MODE_SW_W-1:0]  mode_switch,
    input  logic [`TEMPO_W-1:0]    tempo_switch,
    input  logic [`RETRY_SW_W-1:0] retry_switch,
    output play_mode_t             mode,
    output logic [`TEMPO_W-1:0]    tempo,
    output retry_choice_t          retry
);

    play_mode_t    mode_next;
    retry_choice_t retry_next;

    // Lowest switch bit wins for the mode, highest for the retry
    always_comb begin
        if (mode_switch[0]) begin
            mode_next = MODE_GAME;
        end else if (mode_switch[1]) begin
            mode_next = MODE_FREE;
        end else begin
            mode_next = MODE_NONE;
        end

        if (retry_switch[2]) begin
            retry_next = RETRY_ROUND;
        end else if (retry_switch[1]) begin
            retry_next = RETRY_NOTE;
        end else if (retry_switch[0]) begin
            retry_next = REPLAY_LAST;
        end else begin
            retry_next = RETRY_NONE;
        end
    end

    // Loaded on every cycle the menu step is shown
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            mode  <= MODE_NONE;
            tempo <= '0;
            retry <= RETRY_NONE;
        end else begin
            if (capture_mode) begin
                mode <= mode_next;
            end
            if (capture_tempo) begin
                tempo <= tempo_switch;
            end
            if (capture_retry) begin
                retry <= retry_next;
            end
        end
    end

endmodule

/* verilog/game_sequencer.sv */
`timescale 1ns/1ns

module game_sequencer
    import piano_settings_pkg::*;
    import piano_state_pkg::*;
(
    input  logic          clock,
    input  logic          reset,
    input  logic          start,
    input  logic          press_enter,
    input  logic          pause_done,
    input  logic          song_done,
    input  logic          note_pressed,
    input  logic          note_ok,
    input  logic          timing_ok,
    input  logic          beat_low,
    input  logic          address_is_round,
    input  logic          note_timeout,
    input  logic          song_end,
    input  play_mode_t    mode,
    input  retry_choice_t retry,
    output seq_state_t    state
);

    seq_state_t state_next;
    logic       in_menu;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state <= ST_IDLE;
        end else begin
            state <= state_next;
        end
    end

    assign in_menu = state inside {ST_IDLE, ST_MENU_START, ST_WAIT_MODE,
                                   ST_WAIT_TEMPO, ST_INIT};

    always_comb begin
        state_next = state;

        if (in_menu) begin
            // --------------------
            // Menu, common to both modes
            case (state)
                ST_IDLE: begin
                    if (start) begin
                        state_next = ST_MENU_START;
                    end
                end
                ST_MENU_START: state_next = ST_WAIT_MODE;
                ST_WAIT_MODE: begin
                    if (press_enter) begin
                        state_next = ST_WAIT_TEMPO;
                    end
                end
                ST_WAIT_TEMPO: begin
                    if (press_enter) begin
                        state_next = ST_INIT;
                    end
                end
                ST_INIT: begin
                    case (mode)
                        MODE_GAME: state_next = ST_ROUND_START;
                        MODE_FREE: state_next = ST_FREE_WAIT;
                        default:   state_next = ST_IDLE;
                    endcase
                end
                default: state_next = ST_IDLE;
            endcase
        end else if (mode == MODE_GAME) begin
            // --------------------
            // Call and response game
            case (state)
                ST_ROUND_START: begin
                    if (pause_done) begin
                        state_next = ST_SHOW;
                    end
                end
                ST_SHOW: state_next = ST_SHOW_WAIT;
                ST_SHOW_WAIT: begin
                    if (beat_low) begin
                        state_next = address_is_round ? ST_NOTE_START : ST_SHOW_NEXT;
                    end
                end
                ST_SHOW_NEXT:  state_next = ST_SHOW;
                ST_NOTE_START: state_next = ST_NOTE_WAIT;
                ST_NOTE_WAIT: begin
                    if (note_timeout) begin
                        state_next = ST_MISS_TIME;
                    end else if (note_pressed) begin
                        state_next = ST_NOTE_PLAY;
                    end
                end
                // Held until the key is released
                ST_NOTE_PLAY: begin
                    if (!note_pressed) begin
                        state_next = ST_COMPARE;
                    end
                end
                ST_COMPARE: begin
                    if (!note_ok) begin
                        state_next = ST_MISS_NOTE;
                    end else if (!timing_ok) begin
                        state_next = ST_MISS_TIME;
                    end else if (address_is_round) begin
                        state_next = song_done ? ST_WON : ST_ADVANCE;
                    end else begin
                        state_next = ST_NEXT_NOTE;
                    end
                end
                ST_NEXT_NOTE: state_next = ST_NOTE_WAIT;
                ST_ADVANCE:   state_next = ST_REGISTER;
                ST_REGISTER:  state_next = ST_CHECK_END;
                ST_CHECK_END: state_next = song_end ? ST_WON : ST_ROUND_NEXT;
                ST_ROUND_NEXT: state_next = ST_ROUND_START;
                ST_WON: begin
                    if (start) begin
                        state_next = ST_INIT;
                    end
                end
                ST_MISS_NOTE, ST_MISS_TIME: state_next = ST_ERR_MENU_START;
                ST_ERR_MENU_START: state_next = ST_ERR_MENU;
                // No choice made keeps the menu open
                ST_ERR_MENU: begin
                    if (press_enter) begin
                        case (retry)
                            RETRY_ROUND: state_next = ST_ROUND_START;
                            RETRY_NOTE:  state_next = ST_NOTE_START;
                            REPLAY_LAST: state_next = ST_SHOW_LAST;
                            default:     state_next = ST_ERR_MENU;
                        endcase
                    end
                end
                ST_SHOW_LAST: begin
                    if (beat_low) begin
                        state_next = ST_NOTE_WAIT;
                    end
                end
                default: state_next = ST_IDLE;
            endcase
        end else if (mode == MODE_FREE) begin
            // --------------------
            // Free play
            case (state)
                ST_FREE_WAIT: begin
                    if (note_pressed) begin
                        state_next = ST_NOTE_PLAY;
                    end
                end
                ST_NOTE_PLAY: begin
                    if (!note_pressed) begin
                        state_next = ST_FREE_WAIT;
                    end
                end
                default: state_next = ST_FREE_WAIT;
            endcase
        end else begin
            state_next = ST_IDLE;
        end
    end

endmodule

/* verilog/control_decoder.sv */
`timescale 1ns/1ns

module control_decoder
    import piano_settings_pkg::*;
    import piano_state_pkg::*;
(
    input  seq_state_t state,
    input  play_mode_t mode,
    output logic       clear_note_count,
    output logic       count_note,
    output logic       clear_pause,
    output logic       count_pause,
    output logic       clear_round,
    output logic       count_round,
    output logic       clear_note_timer,
    output logic       count_note_timer,
    output logic       clear_metro,
    output logic       count_metro,
    output logic       clear_key,
    output logic       capture_key,
    output logic       leds_from_memory,
    output logic       leds_on,
    output logic       sound_on,
    output logic       menu_start,
    output logic       menu_visible,
    output logic       capture_mode,
    output logic       capture_tempo,
    output logic       capture_retry,
    output logic       capture_error,
    output logic       won,
    output logic       lost,
    output logic       player_turn,
    output logic [1:0] menu_sel
);

    // --------------------
    // Counters
    assign clear_note_count = state inside {ST_ROUND_START, ST_NOTE_START};
    assign count_note       = state inside {ST_ADVANCE, ST_SHOW_NEXT, ST_NEXT_NOTE};
    assign clear_pause      = state inside {ST_SHOW, ST_INIT, ST_NOTE_START};
    assign count_pause      = (state == ST_ROUND_START);
    assign clear_round      = (state == ST_INIT);
    assign count_round      = (state == ST_ROUND_NEXT);

    // --------------------
    // Timers
    assign clear_note_timer = state inside {ST_NEXT_NOTE, ST_NOTE_START, ST_INIT,
                                            ST_MISS_NOTE, ST_MISS_TIME, ST_CHECK_END};
    assign count_note_timer = (state == ST_NOTE_WAIT);

    // Metronome runs while a note sounds or the player is free
    assign count_metro = state inside {ST_SHOW_WAIT, ST_SHOW_LAST, ST_NOTE_PLAY,
                                       ST_FREE_WAIT};
    assign clear_metro = state inside {ST_SHOW, ST_NOTE_WAIT, ST_MISS_NOTE,
                                       ST_MISS_TIME, ST_INIT, ST_CHECK_END};

    // --------------------
    // Keys, LEDs and sound
    assign clear_key        = (state == ST_IDLE);
    // Free play has nothing to compare against
    assign capture_key      = (state == ST_NOTE_PLAY) && (mode == MODE_GAME);
    assign sound_on         = (state == ST_NOTE_PLAY);
    assign leds_from_memory = state inside {ST_SHOW_WAIT, ST_SHOW_LAST};
    assign leds_on          = state inside {ST_SHOW_WAIT, ST_SHOW_LAST, ST_NOTE_PLAY};

    // --------------------
    // Menu
    assign menu_start    = state inside {ST_MENU_START, ST_ERR_MENU_START};
    assign menu_visible  = state inside {ST_WAIT_MODE, ST_WAIT_TEMPO, ST_ERR_MENU};
    assign capture_mode  = (state == ST_WAIT_MODE);
    assign capture_tempo = (state == ST_WAIT_TEMPO);
    assign capture_retry = (state == ST_ERR_MENU);
    assign capture_error = (state == ST_COMPARE);

    always_comb begin
        case (state)
            ST_WAIT_TEMPO: menu_sel = 2'd1;
            ST_ERR_MENU:   menu_sel = 2'd2;
            default:       menu_sel = 2'd0;
        endcase
    end

    // --------------------
    // Status
    assign won         = (state == ST_WON);
    assign lost        = state inside {ST_MISS_NOTE, ST_MISS_TIME};
    assign player_turn = (state == ST_NOTE_WAIT);

endmodule

/* verilog/piano_control.sv */
`timescale 1ns/1ns
`include "piano_control_cfg.svh"

module piano_control
    import piano_settings_pkg::*;
    import piano_state_pkg::*;
(
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   start,
    input  logic                   press_enter,
    input  logic                   pause_done,
    input  logic                   song_done,
    input  logic                   note_pressed,
    input  logic                   note_ok,
    input  logic                   timing_ok,
    input  logic                   beat_low,
    input  logic                   address_is_round,
    input  logic                   note_timeout,
    input  logic                   song_end,
    input  logic [`MODE_SW_W-1:0]  mode_switch,
    input  logic [`TEMPO_W-1:0]    tempo_switch,
    input  logic [`RETRY_SW_W-1:0] retry_switch,
    output logic [`TEMPO_W-1:0]    tempo,
    output logic                   clear_note_count,
    output logic                   count_note,
    output logic                   clear_pause,
    output logic                   count_pause,
    output logic                   clear_round,
    output logic                   count_round,
    output logic                   clear_note_timer,
    output logic                   count_note_timer,
    output logic                   clear_metro,
    output logic                   count_metro,
    output logic                   clear_key,
    output logic                   capture_key,
    output logic                   leds_from_memory,
    output logic                   leds_on,
    output logic                   sound_on,
    output logic                   menu_start,
    output logic                   menu_visible,
    output logic                   capture_error,
    output logic                   won,
    output logic                   lost,
    output logic                   player_turn,
    output logic [1:0]             menu_sel,
    output logic [`STATE_W-1:0]    state_debug
);

    play_mode_t    mode;
    retry_choice_t retry;
    seq_state_t    state;
    logic          capture_mode;
    logic          capture_tempo;
    logic          capture_retry;

    assign state_debug = state;

    settings_registers u_settings_registers (
        .clock         (clock),
        .reset         (reset),
        .capture_mode  (capture_mode),
        .capture_tempo (capture_tempo),
        .capture_retry (capture_retry),
        .mode_switch   (mode_switch),
        .tempo_switch  (tempo_switch),
        .retry_switch  (retry_switch),
        .mode          (mode),
        .tempo         (tempo),
        .retry         (retry)
    );

    game_sequencer u_game_sequencer (
        .clock            (clock),
        .reset            (reset),
        .start            (start),
        .press_enter      (press_enter),
        .pause_done       (pause_done),
        .song_done        (song_done),
        .note_pressed     (note_pressed),
        .note_ok          (note_ok),
        .timing_ok        (timing_ok),
        .beat_low         (beat_low),
        .address_is_round (address_is_round),
        .note_timeout     (note_timeout),
        .song_end         (song_end),
        .mode             (mode),
        .retry            (retry),
        .state            (state)
    );

    // Decoder port names match the top level one for one
    control_decoder u_control_decoder (.*);

endmodule

/* verification/piano_control_table.svh */
// Columns: conditions, mode, tempo and retry switches, expected state, flags, expected tempo
// Conditions: reset | start enter | pause_done song_done | note_pressed note_ok timing_ok
//             | beat_low address_is_round | note_timeout song_end
// Flags: won lost player_turn menu_visible
task automatic build_table();
    // --------------------
    // Reset and menu, game at tempo 2
    add_row(12'b0_00_00_000_00_00, 2'b00, 2'b00, 3'b000, ST_IDLE,           4'b0000, 2'd0);
    add_row(12'b0_10_00_000_00_00, 2'b00, 2'b00, 3'b000, ST_MENU_START,     4'b0000, 2'd0);
    add_row(12'b0_00_00_000_00_00, 2'b01, 2'b10, 3'b000, ST_WAIT_MODE,      4'b0001, 2'd0);
    add_row(12'b0_01_00_000_00_00, 2'b01, 2'b10, 3'b000, ST_WAIT_TEMPO,     4'b0001, 2'd0);
    add_row(12'b0_01_00_000_00_00, 2'b01, 2'b10, 3'b000, ST_INIT,           4'b0000, 2'd2);
    add_row(12'b0_00_00_000_00_00, 2'b01, 2'b10, 3'b000, ST_ROUND_START,    4'b0000, 2'd2);
    // --------------------
    // One note round, then the song ends
    add_row(12'b0_00_10_000_00_00, 2'b01, 2'b10, 3'b000, ST_SHOW,           4'b0000, 2'd2);
    add_row(12'b0_00_00_000_00_00, 2'b01, 2'b10, 3'b000, ST_SHOW_WAIT,      4'b0000, 2'd2);
    add_row(12'b0_00_00_000_11_00, 2'b01, 2'b10, 3'b000, ST_NOTE_START,     4'b0000, 2'd2);
    add_row(12'b0_00_00_000_00_00, 2'b01, 2'b10, 3'b000, ST_NOTE_WAIT,      4'b0010, 2'd2);
    add_row(12'b0_00_00_100_00_00, 2'b01, 2'b10, 3'b000, ST_NOTE_PLAY,      4'b0000, 2'd2);
    add_row(12'b0_00_00_011_01_00, 2'b01, 2'b10, 3'b000, ST_COMPARE,        4'b0000, 2'd2);
    add_row(12'b0_00_00_011_01_00, 2'b01, 2'b10, 3'b000, ST_ADVANCE,        4'b0000, 2'd2);
    add_row(12'b0_00_00_000_00_00, 2'b01, 2'b10, 3'b000, ST_REGISTER,       4'b0000, 2'd2);
    add_row(12'b0_00_00_000_00_00, 2'b01, 2'b10, 3'b000, ST_CHECK_END,      4'b0000, 2'd2);
    add_row(12'b0_00_00_000_00_01, 2'b01, 2'b10, 3'b000, ST_WON,            4'b1000, 2'd2);
    add_row(12'b0_10_00_000_00_00, 2'b01, 2'b10, 3'b000, ST_INIT,           4'b0000, 2'd2);
    add_row(12'b0_00_00_000_00_00, 2'b01, 2'b10, 3'b000, ST_ROUND_START,    4'b0000, 2'd2);
    // --------------------
    // Two notes shown, wrong note, retry round
    add_row(12'b0_00_10_000_00_00, 2'b01, 2'b10, 3'b000, ST_SHOW,           4'b0000, 2'd2);
    add_row(12'b0_00_00_000_00_00, 2'b01, 2'b10, 3'b000, ST_SHOW_WAIT,      4'b0000, 2'd2);
    add_row(12'b0_00_00_000_10_00, 2'b01, 2'b10, 3'b000, ST_SHOW_NEXT,      4'b0000, 2'd2);
    add_row(12'b0_00_00_000_00_00, 2'b01, 2'b10, 3'b000, ST_SHOW,           4'b0000, 2'd2);
    add_row(12'b0_00_00_000_00_00, 2'b01, 2'b10, 3'b000, ST_SHOW_WAIT,      4'b0000, 2'd2);
    add_row(12'b0_00_00_000_11_00, 2'b01, 2'b10, 3'b000, ST_NOTE_START,     4'b0000, 2'd2);
    add_row(12'b0_00_00_000_00_00, 2'b01, 2'b10, 3'b000, ST_NOTE_WAIT,      4'b0010, 2'd2);
    add_row(12'b0_00_00_100_00_00, 2'b01, 2'b10, 3'b000, ST_NOTE_PLAY,      4'b0000, 2'd2);
    add_row(12'b0_00_00_000_00_00, 2'b01, 2'b10, 3'b000, ST_COMPARE,        4'b0000, 2'd2);
    add_row(12'b0_00_00_001_00_00, 2'b01, 2'b10, 3'b000, ST_MISS_NOTE,      4'b0100, 2'd2);
    add_row(12'b0_00_00_000_00_00, 2'b01, 2'b10, 3'b100, ST_ERR_MENU_START, 4'b0000, 2'd2);
    add_row(12'b0_00_00_000_00_00, 2'b01, 2'b10, 3'b100, ST_ERR_MENU,       4'b0001, 2'd2);
    // No choice held yet, so the first enter keeps the menu
    add_row(12'b0_01_00_000_00_00, 2'b01, 2'b10, 3'b100, ST_ERR_MENU,       4'b0001, 2'd2);
    add_row(12'b0_01_00_000_00_00, 2'b01, 2'b10, 3'b100, ST_ROUND_START,    4'b0000, 2'd2);
    // --------------------
    // Timeout, retry note, then wrong timing and replay last
    add_row(12'b0_00_10_000_00_00, 2'b01, 2'b10, 3'b100, ST_SHOW,           4'b0000, 2'd2);
    add_row(12'b0_00_00_000_00_00, 2'b01, 2'b10, 3'b100, ST_SHOW_WAIT,      4'b0000, 2'd2);
    add_row(12'b0_00_00_000_11_00, 2'b01, 2'b10, 3'b100, ST_NOTE_START,     4'b0000, 2'd2);
    add_row(12'b0_00_00_000_00_00, 2'b01, 2'b10, 3'b100, ST_NOTE_WAIT,      4'b0010, 2'd2);
    add_row(12'b0_00_00_100_00_10, 2'b01, 2'b10, 3'b100, ST_MISS_TIME,      4'b0100, 2'd2);
    add_row(12'b0_00_00_000_00_00, 2'b01, 2'b10, 3'b010, ST_ERR_MENU_START, 4'b0000, 2'd2);
    add_row(12'b0_00_00_000_00_00, 2'b01, 2'b10, 3'b010, ST_ERR_MENU,       4'b0001, 2'd2);
    add_row(12'b0_00_00_000_00_00, 2'b01, 2'b10, 3'b010, ST_ERR_MENU,       4'b0001, 2'd2);
    add_row(12'b0_01_00_000_00_00, 2'b01, 2'b10, 3'b010, ST_NOTE_START,     4'b0000, 2'd2);
    add_row(12'b0_00_00_000_00_00, 2'b01, 2'b10, 3'b010, ST_NOTE_WAIT,      4'b0010, 2'd2);
    add_row(12'b0_00_00_100_00_00, 2'b01, 2'b10, 3'b010, ST_NOTE_PLAY,      4'b0000, 2'd2);
    add_row(12'b0_00_00_000_00_00, 2'b01, 2'b10, 3'b010, ST_COMPARE,        4'b0000, 2'd2);
    add_row(12'b0_00_00_010_00_00, 2'b01, 2'b10, 3'b010, ST_MISS_TIME,      4'b0100, 2'd2);
    add_row(12'b0_00_00_000_00_00, 2'b01, 2'b10, 3'b001, ST_ERR_MENU_START, 4'b0000, 2'd2);
    add_row(12'b0_00_00_000_00_00, 2'b01, 2'b10, 3'b001, ST_ERR_MENU,       4'b0001, 2'd2);
    add_row(12'b0_00_00_000_00_00, 2'b01, 2'b10, 3'b001, ST_ERR_MENU,       4'b0001, 2'd2);
    add_row(12'b0_01_00_000_00_00, 2'b01, 2'b10, 3'b001, ST_SHOW_LAST,      4'b0000, 2'd2);
    add_row(12'b0_00_00_000_10_00, 2'b01, 2'b10, 3'b001, ST_NOTE_WAIT,      4'b0010, 2'd2);
    add_row(12'b0_00_00_100_00_00, 2'b01, 2'b10, 3'b001, ST_NOTE_PLAY,      4'b0000, 2'd2);
    add_row(12'b0_00_00_011_00_00, 2'b01, 2'b10, 3'b001, ST_COMPARE,        4'b0000, 2'd2);
    add_row(12'b0_00_00_011_00_00, 2'b01, 2'b10, 3'b001, ST_NEXT_NOTE,      4'b0000, 2'd2);
    add_row(12'b0_00_00_000_00_00, 2'b01, 2'b10, 3'b001, ST_NOTE_WAIT,      4'b0010, 2'd2);
    // --------------------
    // Reset, then free play at tempo 1
    add_row(12'b1_00_00_000_00_00, 2'b00, 2'b00, 3'b000, ST_IDLE,           4'b0000, 2'd0);
    add_row(12'b0_10_00_000_00_00, 2'b00, 2'b00, 3'b000, ST_MENU_START,     4'b0000, 2'd0);
    add_row(12'b0_00_00_000_00_00, 2'b10, 2'b01, 3'b000, ST_WAIT_MODE,      4'b0001, 2'd0);
    add_row(12'b0_01_00_000_00_00, 2'b10, 2'b01, 3'b000, ST_WAIT_TEMPO,     4'b0001, 2'd0);
    add_row(12'b0_01_00_000_00_00, 2'b10, 2'b01, 3'b000, ST_INIT,           4'b0000, 2'd1);
    add_row(12'b0_00_00_000_00_00, 2'b10, 2'b01, 3'b000, ST_FREE_WAIT,      4'b0000, 2'd1);
    add_row(12'b0_00_00_100_00_00, 2'b10, 2'b01, 3'b000, ST_NOTE_PLAY,      4'b0000, 2'd1);
    add_row(12'b0_00_00_000_00_00, 2'b10, 2'b01, 3'b000, ST_FREE_WAIT,      4'b0000, 2'd1);
endtask

/* verification/piano_control_tb.sv */
`timescale 1ns/1ns
`include "piano_control_cfg.svh"

module piano_control_tb
    import piano_state_pkg::*;
();

    // One table row, inputs first and expected values after
    typedef struct packed {
        logic [11:0]         conditions;
        logic [1:0]          mode_sw;
        logic [1:0]          tempo_sw;
        logic [2:0]          retry_sw;
        logic [`STATE_W-1:0] state;
        logic [3:0]          flags;
        logic [1:0]          tempo_exp;
    } row_t;

    logic                clock;
    logic                reset;
    logic [10:0]         conditions;
    logic [1:0]          mode_switch;
    logic [1:0]          tempo_switch;
    logic [2:0]          retry_switch;
    logic [`STATE_W-1:0] state_debug;
    logic [1:0]          tempo;
    logic                won;
    logic                lost;
    logic                player_turn;
    logic                menu_visible;
    logic [1:0]          menu_sel;
    logic [0:16]         strobes;
    logic                game_mode;
    logic [`STATE_W-1:0] prev_state;
    row_t                rows[$];
    int                  cycles = 0;
    int                  cycle_limit = 0;

    string strobe_names[17] = '{
        "clear_note_count", "count_note", "clear_pause", "count_pause",
        "clear_round", "count_round", "clear_note_timer", "count_note_timer",
        "clear_metro", "count_metro", "clear_key", "capture_key",
        "leds_from_memory", "leds_on", "sound_on", "menu_start", "capture_error"
    };

    piano_control u_piano_control (
        .clock            (clock),
        .reset            (reset),
        .start            (conditions[10]),
        .press_enter      (conditions[9]),
        .pause_done       (conditions[8]),
        .song_done        (conditions[7]),
        .note_pressed     (conditions[6]),
        .note_ok          (conditions[5]),
        .timing_ok        (conditions[4]),
        .beat_low         (conditions[3]),
        .address_is_round (conditions[2]),
        .note_timeout     (conditions[1]),
        .song_end         (conditions[0]),
        .mode_switch      (mode_switch),
        .tempo_switch     (tempo_switch),
        .retry_switch     (retry_switch),
        .tempo            (tempo),
        .clear_note_count (strobes[0]),
        .count_note       (strobes[1]),
        .clear_pause      (strobes[2]),
        .count_pause      (strobes[3]),
        .clear_round      (strobes[4]),
        .count_round      (strobes[5]),
        .clear_note_timer (strobes[6]),
        .count_note_timer (strobes[7]),
        .clear_metro      (strobes[8]),
        .count_metro      (strobes[9]),
        .clear_key        (strobes[10]),
        .capture_key      (strobes[11]),
        .leds_from_memory (strobes[12]),
        .leds_on          (strobes[13]),
        .sound_on         (strobes[14]),
        .menu_start       (strobes[15]),
        .capture_error    (strobes[16]),
        .menu_visible     (menu_visible),
        .won              (won),
        .lost             (lost),
        .player_turn      (player_turn),
        .menu_sel         (menu_sel),
        .state_debug      (state_debug)
    );

    always #2 clock = ~clock;

    task automatic add_row(input logic [11:0] conditions_in, input logic [1:0] mode_in,
                           input logic [1:0] tempo_in, input logic [2:0] retry_in,
                           input seq_state_t state_in, input logic [3:0] flags_in,
                           input logic [1:0] tempo_in_exp);
        row_t row;
        row.conditions = conditions_in;
        row.mode_sw    = mode_in;
        row.tempo_sw   = tempo_in;
        row.retry_sw   = retry_in;
        row.state      = state_in;
        row.flags      = flags_in;
        row.tempo_exp  = tempo_in_exp;
        rows.push_back(row);
    endtask

`include "piano_control_table.svh"

    // Strobes on in each state, in the order of strobe_names
    // Groups: counters | timers and metronome | key, LEDs, sound | menu_start capture_error
    function automatic logic [0:16] strobes_for(input logic [`STATE_W-1:0] st);
        case (st)
            ST_IDLE:                          return 17'b000000_0000_10000_00;
            ST_MENU_START, ST_ERR_MENU_START: return 17'b000000_0000_00000_10;
            ST_INIT:                          return 17'b001010_1010_00000_00;
            ST_ROUND_START:                   return 17'b100100_0000_00000_00;
            ST_SHOW:                          return 17'b001000_0010_00000_00;
            ST_SHOW_WAIT, ST_SHOW_LAST:       return 17'b000000_0001_00110_00;
            ST_SHOW_NEXT, ST_ADVANCE:         return 17'b010000_0000_00000_00;
            ST_NOTE_START:                    return 17'b101000_1000_00000_00;
            ST_NOTE_WAIT:                     return 17'b000000_0110_00000_00;
            // capture_key is further gated by the game mode
            ST_NOTE_PLAY:                     return 17'b000000_0001_01011_00;
            ST_COMPARE:                       return 17'b000000_0000_00000_01;
            ST_NEXT_NOTE:                     return 17'b010000_1000_00000_00;
            ST_CHECK_END:                     return 17'b000000_1010_00000_00;
            ST_ROUND_NEXT:                    return 17'b000001_0000_00000_00;
            ST_MISS_NOTE, ST_MISS_TIME:       return 17'b000000_1010_00000_00;
            ST_FREE_WAIT:                     return 17'b000000_0001_00000_00;
            // Menu waits, REGISTER, WON and ERR_MENU
            default:                          return '0;
        endcase
    endfunction

    task automatic check_value(input string name, input int actual, input int expected);
        if (actual != expected) begin
            $display("Mismatch at %0t ns: %s is %0d, expected %0d",
                     $time, name, actual, expected);
            $display("Test FAILED");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    task automatic check_row(input int index);
        row_t        row;
        logic [0:16] strobes_exp;
        int          menu_sel_exp;
        row = rows[index];
        strobes_exp = strobes_for(row.state);
        strobes_exp[11] = strobes_exp[11] & game_mode;
        check_value($sformatf("state_debug, row %0d", index), int'(state_debug),
                    int'(row.state));
        check_value($sformatf("won, row %0d", index), int'(won), int'(row.flags[3]));
        check_value($sformatf("lost, row %0d", index), int'(lost), int'(row.flags[2]));
        check_value($sformatf("player_turn, row %0d", index), int'(player_turn),
                    int'(row.flags[1]));
        check_value($sformatf("menu_visible, row %0d", index), int'(menu_visible),
                    int'(row.flags[0]));
        check_value($sformatf("tempo, row %0d", index), int'(tempo), int'(row.tempo_exp));
        for (int b = 0; b < 17; b++) begin
            check_value($sformatf("%s, row %0d", strobe_names[b], index), int'(strobes[b]),
                        int'(strobes_exp[b]));
        end
        // Menu page shown while the menu is up
        if (row.flags[0]) begin
            if (row.state == ST_WAIT_TEMPO) begin
                menu_sel_exp = 1;
            end else if (row.state == ST_ERR_MENU) begin
                menu_sel_exp = 2;
            end else begin
                menu_sel_exp = 0;
            end
            check_value($sformatf("menu_sel, row %0d", index), int'(menu_sel), menu_sel_exp);
        end
    endtask

    // --------------------
    // Watchdog
    always @(posedge clock) begin
        cycles = cycles + 1;
        if (cycles > cycle_limit) begin
            $display("Timeout: the table did not finish within %0d clock cycles", cycle_limit);
            $display("Test FAILED");
            $fatal(1, "timeout");
        end
    end

    // --------------------
    // Table loop
    initial begin
        clock        = 1'b0;
        reset        = 1'b1;
        conditions   = '0;
        mode_switch  = '0;
        tempo_switch = '0;
        retry_switch = '0;
        game_mode    = 1'b0;
        prev_state   = ST_IDLE;
        build_table();
        cycle_limit = 2 * rows.size() + 20;

        repeat (5) @(posedge clock);
        #1;
        reset = 1'b0;

        // Each row is sampled at the next edge and checked 1 ns later
        foreach (rows[i]) begin
            // Mode is taken from the switch on an edge that leaves WAIT_MODE's cycle
            if (rows[i].conditions[11]) begin
                game_mode = 1'b0;
            end else if (prev_state == ST_WAIT_MODE) begin
                game_mode = rows[i].mode_sw[0];
            end
            reset        = rows[i].conditions[11];
            conditions   = rows[i].conditions[10:0];
            mode_switch  = rows[i].mode_sw;
            tempo_switch = rows[i].tempo_sw;
            retry_switch = rows[i].retry_sw;
            @(posedge clock);
            #1;
            check_row(i);
            prev_state = rows[i].state;
        end

        $display("Test OK");
        $finish;
    end

endmodule

/* piano_control.f */
+incdir+verilog
+incdir+verification
verilog/piano_settings_pkg.sv
verilog/piano_state_pkg.sv
verilog/settings_registers.sv
verilog/game_sequencer.sv
verilog/control_decoder.sv
verilog/piano_control.sv
verification/piano_control_tb.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ns -f piano_control.f \
    --top-module piano_control_tb -o piano_control_sim

output=$(./obj_dir/piano_control_sim 2>&1)
echo "$output"

if echo "$output" | grep -qx "Test OK"; then
    exit 0
else
    exit 1
fi
